//--- common/core_pkg.sv
/*
 * Shared definitions for the integer execution back end: pipeline widths,
 * the ALU opcode set and the micro-op, operand and result bundles.
 */

package core_pkg;

  // bundle width, one micro-op per ALU lane
  localparam int LANE_COUNT = 3;

  localparam int XLEN = 32;
  localparam int REG_COUNT = 32;
  localparam int REG_INDEX_BITS = 5;

  // immediate is sign-extended to XLEN in the lane
  localparam int IMM_BITS = 12;

  // rs1 and rs2 for every lane
  localparam int READ_PORTS = 2 * LANE_COUNT;

  // edges from the issue strobe to the retire strobe
  localparam int RETIRE_LATENCY = 3;

  typedef logic [REG_INDEX_BITS-1:0] reg_index_t;
  typedef logic [XLEN-1:0] word_t;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,
    op_slt  = 4'd8,
    op_sltu = 4'd9
  } alu_op_e;

  // one decoded ALU micro-op
  typedef struct packed {
    logic                valid;
    alu_op_e             op;
    logic                use_imm;
    reg_index_t          rd;
    reg_index_t          rs1;
    reg_index_t          rs2;
    logic [IMM_BITS-1:0] imm;
  } uop_t;

  typedef uop_t [LANE_COUNT-1:0] uop_bundle_t;

  // lane input: the micro-op with its source values already read
  typedef struct packed {
    uop_t  uop;
    word_t src1;
    word_t src2;
  } operand_t;

  // write is low for results that must not update the register file
  typedef struct packed {
    logic       valid;
    logic       write;
    reg_index_t rd;
    word_t      data;
  } result_t;

  typedef result_t [LANE_COUNT-1:0] result_bundle_t;

endpackage

//--- verilog/reg_file.sv
/*
 * Integer register file, 32 words with six asynchronous read ports and
 * three write ports where the highest lane wins on a shared destination.
 */

`timescale 1ns/1ps

module reg_file
  import core_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  reg_index_t [READ_PORTS-1:0] read_index,
  output word_t      [READ_PORTS-1:0] read_data,
  input  result_bundle_t              write_port
);

  word_t regs [REG_COUNT];

  // ascending lane order, so the last (highest) matching lane sticks
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        if (write_port[i].valid && write_port[i].write) begin
          regs[write_port[i].rd] <= write_port[i].data;
        end
      end
    end
  end

  // results on the write port retire this cycle
  // forwarding them makes a retiring bundle visible to the bundle being read now
  always_comb begin
    for (int p = 0; p < READ_PORTS; p++) begin
      read_data[p] = regs[read_index[p]];
      for (int i = 0; i < LANE_COUNT; i++) begin
        if (write_port[i].valid && write_port[i].write &&
            write_port[i].rd == read_index[p]) begin
          read_data[p] = write_port[i].data;
        end
      end
    end
  end

endmodule

//--- verilog/operand_read.sv
/*
 * Operand read stage. Captures an issued bundle, looks up its sources in
 * the register file and hands each lane its micro-op with both operands.
 */

`timescale 1ns/1ps

module operand_read
  import core_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        issue_valid,
  input  uop_bundle_t                 issue_bundle,
  output reg_index_t [READ_PORTS-1:0] read_index,
  input  word_t      [READ_PORTS-1:0] read_data,
  output operand_t   [LANE_COUNT-1:0] lane_in
);

  uop_bundle_t bundle_q;

  // issue register
  // payload is taken every cycle, only the valids matter downstream
  always_ff @(posedge clock) begin
    bundle_q <= issue_bundle;
    if (reset) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        bundle_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        bundle_q[i].valid <= issue_bundle[i].valid & issue_valid & ~flush;
      end
    end
  end

  // port 2i is rs1 of lane i, port 2i+1 its rs2
  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      read_index[2*i]   = bundle_q[i].rs1;
      read_index[2*i+1] = bundle_q[i].rs2;
    end
  end

  // operand register, one per lane
  always_ff @(posedge clock) begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      lane_in[i].uop  <= bundle_q[i];
      lane_in[i].src1 <= read_data[2*i];
      lane_in[i].src2 <= read_data[2*i+1];
    end
    if (reset) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        lane_in[i].uop.valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        lane_in[i].uop.valid <= bundle_q[i].valid & ~flush;
      end
    end
  end

endmodule

//--- alu_lane/alu_lane.sv
/*
 * Two-stage integer ALU lane. Stage one evaluates the operation on the
 * incoming operands, stage two holds the result for write back.
 */

`timescale 1ns/1ps

module alu_lane
  import core_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  operand_t lane_in,
  output result_t  result
);

  word_t      imm_ext;
  word_t      op_b;
  word_t      alu_out;
  logic [4:0] shamt;
  result_t    stage_one_q;

  always_comb begin
    imm_ext = {{(XLEN-IMM_BITS){lane_in.uop.imm[IMM_BITS-1]}}, lane_in.uop.imm};
    op_b    = lane_in.uop.use_imm ? imm_ext : lane_in.src2;
    // only the low five bits shift
    shamt   = op_b[4:0];
    case (lane_in.uop.op)
      op_add:  alu_out = lane_in.src1 + op_b;
      op_sub:  alu_out = lane_in.src1 - op_b;
      op_and:  alu_out = lane_in.src1 & op_b;
      op_or:   alu_out = lane_in.src1 | op_b;
      op_xor:  alu_out = lane_in.src1 ^ op_b;
      op_sll:  alu_out = lane_in.src1 << shamt;
      op_srl:  alu_out = lane_in.src1 >> shamt;
      op_sra:  alu_out = $signed(lane_in.src1) >>> shamt;
      op_slt: begin
        alu_out = {{(XLEN-1){1'b0}}, $signed(lane_in.src1) < $signed(op_b)};
      end
      op_sltu: begin
        alu_out = {{(XLEN-1){1'b0}}, lane_in.src1 < op_b};
      end
      default: alu_out = '0;
    endcase
  end

  // stage one
  always_ff @(posedge clock) begin
    stage_one_q.rd    <= lane_in.uop.rd;
    stage_one_q.data  <= alu_out;
    stage_one_q.write <= lane_in.uop.valid;
    if (reset) begin
      stage_one_q.valid <= 1'b0;
    end else begin
      stage_one_q.valid <= lane_in.uop.valid & ~flush;
    end
  end

  // stage two
  // a bundle entering here at the flush edge was issued before the flush
  // window and still retires
  always_ff @(posedge clock) begin
    result.rd    <= stage_one_q.rd;
    result.data  <= stage_one_q.data;
    result.write <= stage_one_q.write;
    if (reset) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= stage_one_q.valid;
    end
  end

endmodule

//--- verilog/write_back.sv
/*
 * Write back stage. Gathers the lane results, drops writes to register
 * zero and presents the same bundle to the register file and retire port.
 */

`timescale 1ns/1ps

module write_back
  import core_pkg::*;
(
  input  result_t [LANE_COUNT-1:0] lane_result,
  output result_bundle_t           write_port,
  output logic                     retire_valid,
  output result_bundle_t           retire_bundle
);

  result_bundle_t filtered;
  logic           any_valid;

  // register zero is hardwired, a result aimed at it retires without a write
  // and keeps its data so the retire port still shows what was computed
  always_comb begin
    filtered = lane_result;
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (lane_result[i].rd == '0) begin
        filtered[i].write = 1'b0;
      end
    end
  end

  // an empty bundle produces no retire strobe
  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < LANE_COUNT; i++) begin
      any_valid = any_valid | lane_result[i].valid;
    end
  end

  assign write_port    = filtered;
  assign retire_bundle = filtered;
  assign retire_valid  = any_valid;

endmodule

//--- verilog/exec_core.sv
/*
 * Execution back end top level. Issued bundles pass through operand read,
 * three two-stage ALU lanes and write back, retiring three edges after issue.
 */

`timescale 1ns/1ps

module exec_core
  import core_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           issue_valid,
  input  uop_bundle_t    issue_bundle,
  input  logic           flush,
  output logic           retire_valid,
  output result_bundle_t retire_bundle
);

  reg_index_t [READ_PORTS-1:0] read_index;
  word_t      [READ_PORTS-1:0] read_data;
  operand_t   [LANE_COUNT-1:0] lane_in;
  result_t    [LANE_COUNT-1:0] lane_result;
  result_bundle_t              write_port;

  operand_read operand_read_inst (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .issue_valid  (issue_valid),
    .issue_bundle (issue_bundle),
    .read_index   (read_index),
    .read_data    (read_data),
    .lane_in      (lane_in)
  );

  reg_file reg_file_inst (
    .clock      (clock),
    .reset      (reset),
    .read_index (read_index),
    .read_data  (read_data),
    .write_port (write_port)
  );

  // lanes are identical, lane i executes slot i of the bundle
  generate
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
      alu_lane alu_lane_inst (
        .clock   (clock),
        .reset   (reset),
        .flush   (flush),
        .lane_in (lane_in[i]),
        .result  (lane_result[i])
      );
    end
  endgenerate

  write_back write_back_inst (
    .lane_result   (lane_result),
    .write_port    (write_port),
    .retire_valid  (retire_valid),
    .retire_bundle (retire_bundle)
  );

endmodule

//--- verif/exec_core_chk.sv
/*
 * Protocol assertions for the execution back end, bound to the top level.
 */

`timescale 1ns/1ps

module exec_core_chk
  import core_pkg::*;
(
  input logic           clock,
  input logic           reset,
  input logic           issue_valid,
  input logic           flush,
  input logic           retire_valid,
  input result_bundle_t retire_bundle
);

  // retire seen one edge late, so the issue edge is four samples back
  // and a flush at the issue edge or either of the next two kills it
  property retire_follows_issue;
    @(posedge clock) disable iff (reset)
      retire_valid |-> $past(issue_valid, 4) && !$past(flush, 4) &&
                       !$past(flush, 3) && !$past(flush, 2);
  endproperty
  assert property (retire_follows_issue) else $error("retire without a live issue");

  generate
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_zero
      assert property (@(posedge clock) disable iff (reset)
        (retire_valid && retire_bundle[i].valid) |->
          !(retire_bundle[i].write && retire_bundle[i].rd == '0))
        else $error("lane writes register zero");
    end
  endgenerate

  // quiet during reset and for three edges after it
  assert property (@(posedge clock)
    ($past(reset, 1) || $past(reset, 2) || $past(reset, 3) || $past(reset, 4)) |->
      !retire_valid)
    else $error("retire strobe too close to reset");

endmodule

bind exec_core exec_core_chk exec_core_chk_inst (
  .clock         (clock),
  .reset         (reset),
  .issue_valid   (issue_valid),
  .flush         (flush),
  .retire_valid  (retire_valid),
  .retire_bundle (retire_bundle)
);

//--- verif/exec_core_tb.sv
/*
 * Testbench for the execution back end. Drives issue bundles, keeps a
 * reference model of the register file and checks every retired bundle.
 */

`timescale 1ns/1ps

module exec_core_tb;
  import core_pkg::*;

  logic           clock;
  logic           reset;
  logic           issue_valid;
  logic           flush;
  uop_bundle_t    issue_bundle;
  logic           retire_valid;
  result_bundle_t retire_bundle;

  logic [31:0]    lcg_state = 32'h4d51;
  word_t          model_regs [REG_COUNT];
  // bundles in flight indexed by issue edge modulo four
  logic           slot_valid [4];
  result_bundle_t slot_res [4];
  int unsigned    edge_n = 0;
  logic           exp_valid = 1'b0;
  result_bundle_t exp_bundle;
  int             check_errors = 0;
  int             timeout_errors = 0;
  int             issued = 0;
  int             killed = 0;
  int             dut_retired = 0;

  exec_core exec_core_inst (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_bundle  (issue_bundle),
    .flush         (flush),
    .retire_valid  (retire_valid),
    .retire_bundle (retire_bundle)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
    word_t      r;
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_sll:  r = a << sh;
      op_srl:  r = a >> sh;
      op_sra:  r = word_t'($signed(a) >>> sh);
      op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sltu: r = (a < b) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic uop_t make_uop(alu_op_e op, logic use_imm, int rd, int rs1, int rs2,
                                    logic [IMM_BITS-1:0] imm);
    uop_t u;
    u.valid   = 1'b1;
    u.op      = op;
    u.use_imm = use_imm;
    u.rd      = reg_index_t'(rd);
    u.rs1     = reg_index_t'(rs1);
    u.rs2     = reg_index_t'(rs2);
    u.imm     = imm;
    return u;
  endfunction

  function automatic uop_t random_uop(int rd, int rs1, int rs2);
    alu_op_e op;
    op = alu_op_e'(4'(lcg_next() % 32'd10));
    return make_uop(op, 1'(lcg_next() >> 20), rd, rs1, rs2, 12'(lcg_next() >> 8));
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    check_errors++;
  endtask

  task automatic send(uop_bundle_t b, logic kill);
    @(posedge clock);
    issue_valid  <= 1'b1;
    issue_bundle <= b;
    flush        <= kill;
  endtask

  task automatic idle();
    @(posedge clock);
    issue_valid <= 1'b0;
    flush       <= 1'b0;
  endtask

  // wait until every issued bundle has retired from the DUT or been killed
  task automatic drain();
    int waited;
    waited = 0;
    idle();
    @(negedge clock);
    while (issued != dut_retired + killed && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (issued != dut_retired + killed) begin
      $display("timeout: issued bundles never left the pipeline");
      timeout_errors++;
    end
  endtask

  // retire strobes counted at the edge that ends them
  always @(posedge clock) begin
    if (!reset && retire_valid) begin
      dut_retired++;
    end
  end

  // reference model sampled at the same edge as the DUT
  always @(posedge clock) begin
    logic [1:0]     old_slot;
    logic [1:0]     new_slot;
    logic [1:0]     s;
    logic           any;
    uop_t           u;
    word_t          a;
    word_t          b;
    result_bundle_t res;
    if (reset) begin
      for (int r = 0; r < REG_COUNT; r++) begin
        model_regs[r] = '0;
      end
      for (int k = 0; k < 4; k++) begin
        slot_valid[k] = 1'b0;
      end
      exp_valid = 1'b0;
      edge_n = 0;
    end else begin
      old_slot = 2'(edge_n - RETIRE_LATENCY);
      exp_valid = slot_valid[old_slot];
      exp_bundle = slot_res[old_slot];
      if (exp_valid) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
          if (exp_bundle[i].valid && exp_bundle[i].write) begin
            model_regs[exp_bundle[i].rd] = exp_bundle[i].data;
          end
        end
      end
      if (flush) begin
        for (int k = 1; k <= 2; k++) begin
          s = 2'(edge_n - k);
          if (slot_valid[s]) begin
            killed++;
          end
          slot_valid[s] = 1'b0;
        end
      end
      new_slot = 2'(edge_n);
      slot_valid[new_slot] = 1'b0;
      any = 1'b0;
      for (int i = 0; i < LANE_COUNT; i++) begin
        u = issue_bundle[i];
        a = model_regs[u.rs1];
        b = u.use_imm ? {{(XLEN-IMM_BITS){u.imm[IMM_BITS-1]}}, u.imm} : model_regs[u.rs2];
        res[i].valid = u.valid;
        res[i].write = (u.rd != '0);
        res[i].rd    = u.rd;
        res[i].data  = alu_ref(u.op, a, b);
        any = any | u.valid;
      end
      if (issue_valid && any) begin
        issued++;
        if (flush) begin
          killed++;
        end else begin
          slot_valid[new_slot] = 1'b1;
          slot_res[new_slot] = res;
        end
      end
      edge_n++;
    end
  end

  // outputs are compared mid-cycle where they are stable
  always @(negedge clock) begin
    if (!reset) begin
      assert (retire_valid === exp_valid)
        else report_mismatch("retire_valid", 32'(retire_valid), 32'(exp_valid));
      if (exp_valid) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
          assert (retire_bundle[i].valid === exp_bundle[i].valid)
            else report_mismatch("retire_bundle.valid", 32'(retire_bundle[i].valid),
                                 32'(exp_bundle[i].valid));
          if (exp_bundle[i].valid) begin
            assert (retire_bundle[i].write === exp_bundle[i].write)
              else report_mismatch("retire_bundle.write", 32'(retire_bundle[i].write),
                                   32'(exp_bundle[i].write));
            assert (retire_bundle[i].rd === exp_bundle[i].rd)
              else report_mismatch("retire_bundle.rd", 32'(retire_bundle[i].rd),
                                   32'(exp_bundle[i].rd));
            assert (retire_bundle[i].data === exp_bundle[i].data)
              else report_mismatch("retire_bundle.data", retire_bundle[i].data,
                                   exp_bundle[i].data);
          end
        end
      end
    end
  end

  initial begin
    uop_bundle_t b;
    uop_bundle_t flush_set [4];
    reset = 1'b1;
    issue_valid = 1'b0;
    flush = 1'b0;
    issue_bundle = '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // fresh registers read as zero
    for (int i = 0; i < LANE_COUNT; i++) begin
      b[i] = make_uop(op_add, 1'b1, 1 + i, 32'(lcg_next() >> 27), 0, 12'(lcg_next() >> 4));
    end
    send(b, 1'b0);
    drain();

    // load every register and then run random operations
    for (int r = 1; r < REG_COUNT; r += LANE_COUNT) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        b[i] = make_uop(op_add, 1'b1, r + i, 0, 0, 12'(lcg_next() >> 12));
        b[i].valid = (r + i < REG_COUNT);
      end
      send(b, 1'b0);
      drain();
    end
    for (int n = 0; n < 40; n++) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        b[i] = random_uop(32'(lcg_next() >> 27), 32'(lcg_next() >> 27),
                          32'(lcg_next() >> 27));
      end
      send(b, 1'b0);
      drain();
    end

    // back to back where each bundle reads the group written three bundles before
    for (int k = 0; k < 20; k++) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        b[i] = random_uop(1 + 3 * (k % 4) + i, 1 + 3 * ((k + 1) % 4) + i,
                          1 + 3 * ((k + 1) % 4) + (i + 1) % 3);
      end
      send(b, 1'b0);
    end
    drain();

    // three writers of r5 while lane 1 reads the old value
    b[0] = make_uop(op_add, 1'b1, 5, 0, 0, 12'h011);
    b[1] = make_uop(op_add, 1'b1, 5, 5, 0, 12'h001);
    b[2] = make_uop(op_add, 1'b1, 5, 0, 0, 12'h077);
    send(b, 1'b0);
    drain();
    b[0] = make_uop(op_add, 1'b1, 6, 5, 0, 12'h000);
    b[1] = make_uop(op_or, 1'b0, 7, 5, 0, 12'h000);
    b[2] = make_uop(op_sub, 1'b0, 8, 5, 6, 12'h000);
    send(b, 1'b0);
    drain();

    // results aimed at register zero
    for (int i = 0; i < LANE_COUNT; i++) begin
      b[i] = make_uop(op_add, 1'b1, 0, 1 + i, 0, 12'h5a5);
    end
    send(b, 1'b0);
    drain();
    for (int i = 0; i < LANE_COUNT; i++) begin
      b[i] = make_uop(op_or, 1'b0, 9 + i, 0, 0, 12'h000);
    end
    send(b, 1'b0);
    drain();

    // flush at the fourth issue edge kills the last three bundles
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        flush_set[k][i] = make_uop(op_add, 1'b1, 20 + 3 * k + i, 0, 0, 12'(lcg_next() >> 16));
      end
      send(flush_set[k], k == 3);
    end
    drain();
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < LANE_COUNT; i++) begin
        b[i] = make_uop(op_add, 1'b1, 1 + i, 20 + 3 * k + i, 0, 12'h000);
      end
      send(b, 1'b0);
      drain();
    end

    $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- exec_core.f
common/core_pkg.sv
verilog/reg_file.sv
verilog/operand_read.sv
alu_lane/alu_lane.sv
verilog/write_back.sv
verilog/exec_core.sv
verif/exec_core_chk.sv
verif/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execution back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module exec_core_tb \
  -f exec_core.f \
  -o exec_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/exec_core_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
  exit 0
else
  exit 1
fi
